//--- Bender.yml
package:
  name: fire_expand_layer

sources:
  - fire_conv_pkg.sv
  - fire_ifm_feeder.sv
  - fire_weight_rom.sv
  - fire_mac_array.sv
  - fire_ofm_requant.sv
  - fire_expand_layer.sv
  - target: test
    files:
      - fire_expand_layer_tb.sv

//--- fire_conv_pkg.sv
package fire_conv_pkg;

	////////////////////
	// Layer geometry
	////////////////////

	// Input channels per output position
	localparam int CHIN = 8;
	// Parallel lanes, one per output channel
	localparam int DSP_NO = 4;
	// Output map is WOUT x WOUT
	localparam int WOUT = 2;
	localparam int NPIX = WOUT * WOUT;

	////////////////////
	// Fixed point format
	////////////////////

	// Pixel and weight words, Q1.14
	localparam int PIX_W = 16;
	localparam int FRAC = 14;
	// Products and sums, Q3.28
	localparam int ACC_W = 2 * PIX_W;

	// Weight table holds quarter steps
	localparam int W_SHIFT = FRAC - 2;
	// Bias table holds quarter steps in accumulator format
	localparam int B_SHIFT = 2 * FRAC - 2;

	// Counter widths
	localparam int CHAN_W = $clog2(CHIN);
	localparam int POS_W = $clog2(NPIX + 1);

	////////////////////
	// Types
	////////////////////

	typedef logic signed [PIX_W-1:0] pixel_t;
	typedef logic signed [ACC_W-1:0] acc_t;
	// Channel index 0 .. CHIN-1
	typedef logic [CHAN_W-1:0] chan_idx_t;
	// Position count 0 .. NPIX
	typedef logic [POS_W-1:0] pos_cnt_t;

endpackage

//--- fire_expand_layer.f
fire_conv_pkg.sv
fire_ifm_feeder.sv
fire_weight_rom.sv
fire_mac_array.sv
fire_ofm_requant.sv
fire_expand_layer.sv
fire_expand_layer_tb.sv

//--- fire_expand_layer.sv
`timescale 1ns/10ps

module fire_expand_layer (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  pixel_valid,
	input  fire_conv_pkg::pixel_t pixel,
	output fire_conv_pkg::pixel_t ofm [fire_conv_pkg::DSP_NO],
	output logic                  ofm_valid,
	output logic                  layer_done
);
	import fire_conv_pkg::*;

	// Feeder to table and lanes
	logic      feed_valid;
	pixel_t    feed_pixel;
	chan_idx_t feed_chan;
	logic      feed_first;
	logic      feed_last;

	// Table outputs
	pixel_t weights [DSP_NO];
	acc_t   biases  [DSP_NO];

	// Lanes to requantizer
	logic sum_valid;
	acc_t sums [DSP_NO];

	////////////////////
	// Input side
	////////////////////

	fire_ifm_feeder fire_ifm_feeder_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.pixel_valid (pixel_valid),
		.pixel       (pixel),
		.layer_done  (layer_done),
		.feed_valid  (feed_valid),
		.feed_pixel  (feed_pixel),
		.feed_chan   (feed_chan),
		.feed_first  (feed_first),
		.feed_last   (feed_last)
	);

	////////////////////
	// Processing
	////////////////////

	fire_weight_rom fire_weight_rom_i (
		.feed_chan (feed_chan),
		.weights   (weights),
		.biases    (biases)
	);

	fire_mac_array fire_mac_array_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.feed_valid (feed_valid),
		.feed_pixel (feed_pixel),
		.feed_first (feed_first),
		.feed_last  (feed_last),
		.weights    (weights),
		.sum_valid  (sum_valid),
		.sums       (sums)
	);

	////////////////////
	// Output side
	////////////////////

	// Done goes back to the feeder to stop acceptance
	fire_ofm_requant fire_ofm_requant_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.sum_valid  (sum_valid),
		.sums       (sums),
		.biases     (biases),
		.ofm        (ofm),
		.ofm_valid  (ofm_valid),
		.layer_done (layer_done)
	);

endmodule

//--- fire_expand_layer_patterns.txt
// Per position: pixel words of channels 0..7 in Q1.14 on the first line
// then the gap flag (0 back-to-back, 1 random gaps) and expected ofm of lanes 0..3
// pass 1 position 0
1000 1000 1000 1000 1000 1000 1000 1000
0000 0000 0000 1C00 2000
// pass 1 position 1, lanes 0 and 3 wrap above bit 28
C000 4000 E000 2000 F000 1000 0000 3000
0000 2C00 0800 0000 5C00
// pass 1 position 2
2000 D000 1000 0000 3000 E000 4000 F000
0000 0000 1400 3000 0000
// pass 1 position 3
0000 2000 4000 F000 E000 3000 D000 1000
0000 1000 0000 4800 4000
// pass 2 position 0
1000 1000 1000 1000 1000 1000 1000 1000
0001 0000 0000 1C00 2000
// pass 2 position 1
C000 4000 E000 2000 F000 1000 0000 3000
0001 2C00 0800 0000 5C00
// pass 2 position 2
2000 D000 1000 0000 3000 E000 4000 F000
0001 0000 1400 3000 0000
// pass 2 position 3
0000 2000 4000 F000 E000 3000 D000 1000
0001 1000 0000 4800 4000

//--- fire_expand_layer_tb.sv
`timescale 1ns/10ps

module fire_expand_layer_tb;
	import fire_conv_pkg::*;

	// Patterns file layout per position: pixels, gap flag, expected lanes
	localparam int POS_WORDS = CHIN + 1 + DSP_NO;
	localparam int FILE_POS = 2 * NPIX;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_CYCLES = RESET_CYCLES + 2 * NPIX * CHIN * 5 + 50;
	// Feeder, lanes and requantizer each add one edge
	localparam int PIPE_EDGES = 3;

	logic   clk;
	logic   arst_n;
	logic   pixel_valid;
	pixel_t pixel;
	pixel_t ofm [DSP_NO];
	logic   ofm_valid;
	logic   layer_done;

	logic [PIX_W-1:0] pattern_mem [FILE_POS * POS_WORDS];
	integer seed = 39971;
	int     cycle_cnt = 0;
	int     errors = 0;
	int     checks = 0;
	int     tests = 0;
	int     failed_tests = 0;
	int     test_mark = 0;

	// Monitor bookkeeping
	int     chan_seen = 0;
	int     strobe_cnt = 0;
	int     last_edge_q [$];
	int     delay_q [$];
	pixel_t ofm_q [$];
	logic   done_q [$];

	fire_expand_layer fire_expand_layer_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.pixel_valid (pixel_valid),
		.pixel       (pixel),
		.ofm         (ofm),
		.ofm_valid   (ofm_valid),
		.layer_done  (layer_done)
	);

	////////////////////
	// Clock and watchdog
	////////////////////

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	initial begin
		while (cycle_cnt < MAX_CYCLES) begin
			@(negedge clk);
		end
		$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("Verification failed");
		$finish;
	end

	////////////////////
	// Monitor
	////////////////////

	// Sampled mid cycle, DUT outputs only move on the rising edge
	always @(negedge clk) begin
		if (arst_n) begin
			// Word taken on the coming edge
			if (pixel_valid && !layer_done) begin
				if (chan_seen == CHIN - 1) begin
					last_edge_q.push_back(cycle_cnt + 1);
					chan_seen = 0;
				end else begin
					chan_seen = chan_seen + 1;
				end
			end
			if (ofm_valid) begin
				for (int o = 0; o < DSP_NO; o++) begin
					ofm_q.push_back(ofm[o]);
				end
				done_q.push_back(layer_done);
				// Edges from last channel accepted to strobe
				if (last_edge_q.size() > 0) begin
					delay_q.push_back(cycle_cnt - last_edge_q.pop_front());
				end else begin
					delay_q.push_back(-1);
				end
				strobe_cnt = strobe_cnt + 1;
			end
		end
	end

	////////////////////
	// Compare tasks
	////////////////////

	task automatic check_ofm(input pixel_t got [DSP_NO], input pixel_t exp [DSP_NO],
		input string what);
		for (int o = 0; o < DSP_NO; o++) begin
			checks++;
			if (got[o] !== exp[o]) begin
				errors++;
				$display("Mismatch at %0d ns: %s lane %0d got %h expected %h",
					$time, what, o, got[o], exp[o]);
			end
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0d ns: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	////////////////////
	// Stimulus helpers
	////////////////////

	// Holds reset, checks quiet outputs, clears monitor state
	task automatic apply_reset();
		@(posedge clk);
		arst_n <= 1'b0;
		pixel_valid <= 1'b0;
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_flag(ofm_valid, 1'b0, "ofm_valid during reset");
			check_flag(layer_done, 1'b0, "layer_done during reset");
		end
		@(posedge clk);
		chan_seen = 0;
		strobe_cnt = 0;
		last_edge_q.delete();
		delay_q.delete();
		ofm_q.delete();
		done_q.delete();
		arst_n <= 1'b1;
	endtask

	// Eight channel words, idle cycles only when the gap flag is set
	task automatic drive_position(input int idx);
		int base;
		int idle;
		base = idx * POS_WORDS;
		for (int k = 0; k < CHIN; k++) begin
			idle = 0;
			if (pattern_mem[base + CHIN] != '0) begin
				idle = $unsigned($random(seed)) % 4;
			end
			repeat (idle) begin
				@(posedge clk);
				pixel_valid <= 1'b0;
			end
			@(posedge clk);
			pixel_valid <= 1'b1;
			pixel <= pixel_t'(pattern_mem[base + k]);
		end
	endtask

	task automatic stop_stream();
		@(posedge clk);
		pixel_valid <= 1'b0;
	endtask

	task automatic wait_strobes(input int n);
		while (strobe_cnt < n) begin
			@(posedge clk);
		end
	endtask

	// Strobes against the file entries of one pass
	task automatic check_results(input int file_pos);
		pixel_t got [DSP_NO];
		pixel_t exp [DSP_NO];
		for (int p = 0; p < NPIX; p++) begin
			for (int o = 0; o < DSP_NO; o++) begin
				got[o] = ofm_q[p * DSP_NO + o];
				exp[o] = pixel_t'(pattern_mem[(file_pos + p) * POS_WORDS + CHIN + 1 + o]);
			end
			check_ofm(got, exp, $sformatf("ofm of file position %0d", file_pos + p));
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors == test_mark) begin
			$display("Test %0d %s: ok", tests, name);
		end else begin
			failed_tests++;
			$display("Test %0d %s: FAIL with %0d mismatches", tests, name, errors - test_mark);
		end
		test_mark = errors;
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		arst_n = 1'b0;
		pixel_valid = 1'b0;
		pixel = '0;
		$readmemh("fire_expand_layer_patterns.txt", pattern_mem);

		apply_reset();
		repeat (2) @(negedge clk);
		check_flag(ofm_valid, 1'b0, "ofm_valid after reset");
		check_flag(layer_done, 1'b0, "layer_done after reset");
		finish_test("reset state");

		// First pass, valid held high across all positions
		for (int p = 0; p < NPIX; p++) begin
			drive_position(p);
		end
		stop_stream();
		wait_strobes(NPIX);
		check_results(0);
		finish_test("back-to-back results");

		for (int p = 0; p < NPIX; p++) begin
			check_flag(delay_q[p] == PIPE_EDGES, 1'b1,
				$sformatf("position %0d strobe after %0d edges", p, delay_q[p]));
		end
		finish_test("strobe timing");

		// Done only with the last strobe, then extra input is ignored
		for (int p = 0; p < NPIX; p++) begin
			check_flag(done_q[p], p == NPIX - 1, $sformatf("layer_done at strobe %0d", p));
		end
		drive_position(0);
		stop_stream();
		repeat (12) @(negedge clk);
		check_flag(strobe_cnt > NPIX, 1'b0, "strobe seen after layer done");
		check_flag(layer_done, 1'b1, "layer_done held");
		finish_test("layer done");

		apply_reset();
		@(negedge clk);
		check_flag(layer_done, 1'b0, "layer_done after second reset");
		finish_test("second reset");

		// Second pass with random gaps
		for (int p = NPIX; p < FILE_POS; p++) begin
			drive_position(p);
		end
		stop_stream();
		wait_strobes(NPIX);
		repeat (12) @(negedge clk);
		check_results(NPIX);
		check_flag(strobe_cnt == NPIX, 1'b1, "one strobe per position");
		finish_test("random gaps");

		for (int p = 0; p < NPIX; p++) begin
			check_flag(done_q[p], p == NPIX - 1, $sformatf("fresh layer_done at strobe %0d", p));
		end
		check_flag(layer_done, 1'b1, "layer_done after full second stream");
		finish_test("fresh layer after reset");

		$display("Tests: %0d run, %0d with errors; checks: %0d, mismatches: %0d",
			tests, failed_tests, checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- fire_ifm_feeder.sv
`timescale 1ns/10ps

module fire_ifm_feeder (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     pixel_valid,
	input  fire_conv_pkg::pixel_t    pixel,
	input  logic                     layer_done,
	output logic                     feed_valid,
	output fire_conv_pkg::pixel_t    feed_pixel,
	output fire_conv_pkg::chan_idx_t feed_chan,
	output logic                     feed_first,
	output logic                     feed_last
);
	import fire_conv_pkg::*;

	logic      accept;
	logic      in_valid;
	pixel_t    in_pixel;
	chan_idx_t chan_cnt;
	logic      chan_wrap;

	////////////////////
	// Input capture
	////////////////////

	// No ready, word taken whenever valid and layer still running
	assign accept = pixel_valid && !layer_done;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			in_valid <= 1'b0;
		end else begin
			in_valid <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			in_pixel <= pixel;
		end
	end

	////////////////////
	// Channel tracking
	////////////////////

	// Last channel of a position
	assign chan_wrap = (chan_cnt == chan_idx_t'(CHIN - 1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			chan_cnt   <= '0;
			feed_valid <= 1'b0;
			feed_first <= 1'b0;
			feed_last  <= 1'b0;
		end else begin
			feed_valid <= in_valid;
			if (in_valid) begin
				chan_cnt   <= chan_wrap ? '0 : chan_cnt + 1'b1;
				// Marks are qualified by feed_valid downstream
				feed_first <= (chan_cnt == '0);
				feed_last  <= chan_wrap;
			end
		end
	end

	// Word and its channel, aligned with the marks
	always_ff @(posedge clk) begin
		if (in_valid) begin
			feed_pixel <= in_pixel;
			feed_chan  <= chan_cnt;
		end
	end

	// One position spans several channels, so a word is never both ends
	a_first_last_excl : assert property (@(posedge clk) disable iff (!arst_n)
		!(feed_first && feed_last))
		else $error("feeder marked a word both first and last channel");

endmodule

//--- fire_mac_array.sv
`timescale 1ns/10ps

module fire_mac_array (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  feed_valid,
	input  fire_conv_pkg::pixel_t feed_pixel,
	input  logic                  feed_first,
	input  logic                  feed_last,
	input  fire_conv_pkg::pixel_t weights [fire_conv_pkg::DSP_NO],
	output logic                  sum_valid,
	output fire_conv_pkg::acc_t   sums    [fire_conv_pkg::DSP_NO]
);
	import fire_conv_pkg::*;

	// Finished position handed over one edge after its last channel
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sum_valid <= 1'b0;
		end else begin
			sum_valid <= feed_valid && feed_last;
		end
	end

	////////////////////
	// MAC lanes
	////////////////////

	for (genvar o = 0; o < DSP_NO; o++) begin : g_lane
		acc_t prod;
		acc_t acc_next;
		acc_t acc;

		// Q1.14 times Q1.14 gives Q3.28, fits without overflow
		assign prod = acc_t'(feed_pixel) * acc_t'(weights[o]);
		// First channel restarts the lane, no clear cycle needed
		assign acc_next = feed_first ? prod : acc + prod;

		always_ff @(posedge clk) begin
			if (feed_valid) begin
				acc <= acc_next;
			end
			// Snapshot frees the lane for the next position
			if (feed_valid && feed_last) begin
				sums[o] <= acc_next;
			end
		end
	end

	// A position must close before the next one opens
	a_first_needs_last : assert property (@(posedge clk) disable iff (!arst_n)
		(feed_valid && feed_first) |=>
			!(feed_valid && feed_first) until_with (feed_valid && feed_last))
		else $error("new position started before previous one closed");

endmodule

//--- fire_ofm_requant.sv
`timescale 1ns/10ps

module fire_ofm_requant (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  sum_valid,
	input  fire_conv_pkg::acc_t   sums    [fire_conv_pkg::DSP_NO],
	input  fire_conv_pkg::acc_t   biases  [fire_conv_pkg::DSP_NO],
	output fire_conv_pkg::pixel_t ofm     [fire_conv_pkg::DSP_NO],
	output logic                  ofm_valid,
	output logic                  layer_done
);
	import fire_conv_pkg::*;

	logic     strobe;
	acc_t     biased [DSP_NO];
	pos_cnt_t pos_cnt;

	// Results after the layer ends are dropped
	assign strobe = sum_valid && !layer_done;

	////////////////////
	// Bias and rectifier
	////////////////////

	always_comb begin
		for (int o = 0; o < DSP_NO; o++) begin
			biased[o] = sums[o] + biases[o];
		end
	end

	// Negative clamps to zero, else keep Q3.28 bits 28..14 as Q1.14
	always_ff @(posedge clk) begin
		if (strobe) begin
			for (int o = 0; o < DSP_NO; o++) begin
				if (biased[o][ACC_W-1]) begin
					ofm[o] <= '0;
				end else begin
					ofm[o] <= {1'b0, biased[o][PIX_W-2+FRAC:FRAC]};
				end
			end
		end
	end

	////////////////////
	// Strobe and layer end
	////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ofm_valid  <= 1'b0;
			pos_cnt    <= '0;
			layer_done <= 1'b0;
		end else begin
			ofm_valid <= strobe;
			if (strobe) begin
				pos_cnt <= pos_cnt + 1'b1;
				// Done rises together with the last strobe
				if (pos_cnt == pos_cnt_t'(NPIX - 1)) begin
					layer_done <= 1'b1;
				end
			end
		end
	end

	// No output once the layer has finished
	a_no_strobe_after_done : assert property (@(posedge clk) disable iff (!arst_n)
		$rose(ofm_valid) |-> !$past(layer_done))
		else $error("output strobe after layer done");

endmodule

//--- fire_weight_rom.sv
`timescale 1ns/10ps

module fire_weight_rom (
	input  fire_conv_pkg::chan_idx_t feed_chan,
	output fire_conv_pkg::pixel_t    weights [fire_conv_pkg::DSP_NO],
	output fire_conv_pkg::acc_t      biases  [fire_conv_pkg::DSP_NO]
);
	import fire_conv_pkg::*;

	// Weight in quarter steps, -4 .. +4
	logic signed [3:0] quarters [DSP_NO];

	////////////////////
	// Weight table
	////////////////////

	// Entry is ((3*lane + 5*chan) mod 9) - 4
	always_comb begin
		case (feed_chan)
			3'd0:    quarters = '{-4'sd4, -4'sd1,  4'sd2, -4'sd4};
			3'd1:    quarters = '{ 4'sd1,  4'sd4, -4'sd2,  4'sd1};
			3'd2:    quarters = '{-4'sd3,  4'sd0,  4'sd3, -4'sd3};
			3'd3:    quarters = '{ 4'sd2, -4'sd4, -4'sd1,  4'sd2};
			3'd4:    quarters = '{-4'sd2,  4'sd1,  4'sd4, -4'sd2};
			3'd5:    quarters = '{ 4'sd3, -4'sd3,  4'sd0,  4'sd3};
			3'd6:    quarters = '{-4'sd1,  4'sd2, -4'sd4, -4'sd1};
			3'd7:    quarters = '{ 4'sd4, -4'sd2,  4'sd1,  4'sd4};
			default: quarters = '{default: '0};
		endcase
	end

	// Sign extend, then scale a quarter to Q1.14
	always_comb begin
		for (int o = 0; o < DSP_NO; o++) begin
			weights[o] = pixel_t'(quarters[o]) <<< W_SHIFT;
		end
	end

	////////////////////
	// Bias table
	////////////////////

	// Lane o gets (o - 1) quarters in Q3.28
	always_comb begin
		for (int o = 0; o < DSP_NO; o++) begin
			biases[o] = acc_t'(o - 1) <<< B_SHIFT;
		end
	end

endmodule
